// File: ccPkg.sv
package ccPkg;

	//////////////////////////////
	// Wordline geometry
	//////////////////////////////

	// Cells in one wordline
	parameter int CellCount = 16;

	// One input cell word, programmed and initial halves
	parameter int WordWidth = 32;

	// One voltage or one programming step
	parameter int VoltWidth = WordWidth / 2;

	typedef logic [VoltWidth-1:0] volt_t;

	// Programmed field on top, initial field below
	typedef struct packed {
		volt_t programmed;
		volt_t initVolt;
	} cellWord_t;

	//////////////////////////////
	// Coupling model
	//////////////////////////////

	// Weight of the cell directly above
	parameter int CouplingY = 8;

	// Weight of each diagonal neighbour
	parameter int CouplingXY = 3;

	// Scale down of the weighted sum, 1/64
	parameter int CouplingShift = 6;

	// Sink side buffer size, also the starting credit count
	parameter int SinkCredits = 2;

endpackage

// File: cciLaneIf.sv
`timescale 1ns/10ps

interface cciLaneIf;
	import ccPkg::*;

	// Lane carries one valid wordline slot
	logic laneValid;

	// Previous wordline programmed voltage of this cell
	volt_t victim;

	// Current wordline step directly above the victim
	volt_t stepSelf;

	// Diagonal steps, zero past the wordline edges
	volt_t stepLeft;
	volt_t stepRight;

	// Loader side
	modport src (
		output laneValid,
		output victim,
		output stepSelf,
		output stepLeft,
		output stepRight
	);

	// Coupling cell side
	modport dst (
		input laneValid,
		input victim,
		input stepSelf,
		input stepLeft,
		input stepRight
	);

endinterface

// File: wordLineLoader.sv
`timescale 1ns/10ps

module wordLineLoader #(
	parameter int WordLinesPerBlock = 8192
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input ccPkg::cellWord_t inWords [ccPkg::CellCount],
	cciLaneIf.src lane [ccPkg::CellCount]
);
	import ccPkg::*;

	localparam int CountWidth = $clog2(WordLinesPerBlock);

	// Wordline position inside the block
	logic [CountWidth-1:0] wordCount;
	logic lastWordLine;
	logic laneValidQ;

	// Present and previous programmed fields
	volt_t presentVolt [CellCount];
	volt_t previousVolt [CellCount];

	// Steps of the latest wordline
	volt_t clampedStep [CellCount];
	volt_t step [CellCount];

	assign lastWordLine = (wordCount == CountWidth'(WordLinesPerBlock - 1));

	// Programmed minus initial, negative goes to zero
	always_comb
	begin
		for (int c = 0; c < CellCount; c++)
		begin
			if (inWords[c].programmed > inWords[c].initVolt)
				clampedStep[c] = inWords[c].programmed - inWords[c].initVolt;
			else
				clampedStep[c] = '0;
		end
	end

	//////////////////////////////
	// Control and present wordline
	//////////////////////////////

	// Present is cleared so the first output after reset is all zeros
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wordCount <= '0;
			laneValidQ <= 1'b0;
			for (int c = 0; c < CellCount; c++)
				presentVolt[c] <= '0;
		end
		else
		begin
			laneValidQ <= inValid;
			if (inValid)
			begin
				for (int c = 0; c < CellCount; c++)
					presentVolt[c] <= inWords[c].programmed;
				// Wrap at block end
				wordCount <= lastWordLine ? '0 : wordCount + 1'b1;
			end
		end
	end

	// Shift present down and load steps
	always_ff @(posedge clk)
	begin
		if (inValid)
		begin
			for (int c = 0; c < CellCount; c++)
			begin
				previousVolt[c] <= presentVolt[c];
				// First wordline of a block couples nothing
				step[c] <= (wordCount == '0) ? '0 : clampedStep[c];
			end
		end
	end

	//////////////////////////////
	// Lane routing
	//////////////////////////////

	for (genvar c = 0; c < CellCount; c++)
	begin : gLane
		assign lane[c].laneValid = laneValidQ;
		assign lane[c].victim = previousVolt[c];
		assign lane[c].stepSelf = step[c];
		if (c == 0)
		begin : gLeftEdge
			assign lane[c].stepLeft = '0;
		end
		else
		begin : gLeft
			assign lane[c].stepLeft = step[c-1];
		end
		if (c == CellCount - 1)
		begin : gRightEdge
			assign lane[c].stepRight = '0;
		end
		else
		begin : gRight
			assign lane[c].stepRight = step[c+1];
		end
	end

	// Counter never leaves the block range
	countInBlock: assert property (@(posedge clk) disable iff (reset)
		int'(wordCount) < WordLinesPerBlock);

endmodule

// File: couplingCell.sv
`timescale 1ns/10ps

module couplingCell (
	input logic clk,
	input logic reset,
	cciLaneIf.dst lane,
	output logic cellValid,
	output ccPkg::volt_t cellVth
);
	import ccPkg::*;

	// Worst case 14 full steps fits in four extra bits
	localparam int SumWidth = VoltWidth + 4;
	localparam int TotalWidth = VoltWidth + 1;

	logic [SumWidth-1:0] weighted;
	logic [SumWidth-1:0] shifted;
	logic [TotalWidth-1:0] total;

	//////////////////////////////
	// Coupling arithmetic
	//////////////////////////////

	always_comb
	begin
		// Vertical term plus both diagonal terms
		weighted = SumWidth'(lane.stepSelf) * SumWidth'(CouplingY)
			+ (SumWidth'(lane.stepLeft) + SumWidth'(lane.stepRight)) * SumWidth'(CouplingXY);
		shifted = weighted >> CouplingShift;
		// One carry bit for the saturation check
		total = {1'b0, lane.victim} + TotalWidth'(shifted);
	end

	// Valid tracks the lane one cycle later
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			cellValid <= 1'b0;
		else
			cellValid <= lane.laneValid;
	end

	// Clip at full scale on carry out
	always_ff @(posedge clk)
	begin
		if (lane.laneValid)
		begin
			if (total[VoltWidth])
				cellVth <= '1;
			else
				cellVth <= total[VoltWidth-1:0];
		end
	end

endmodule

// File: vthCollector.sv
`timescale 1ns/10ps

module vthCollector #(
	parameter int FifoDepth = 4
) (
	input logic clk,
	input logic reset,
	input logic [ccPkg::CellCount-1:0] cellValid,
	input ccPkg::volt_t cellVth [ccPkg::CellCount],
	output logic outValid,
	output ccPkg::volt_t outVth [ccPkg::CellCount],
	input logic outCredit,
	output logic inCredit
);
	import ccPkg::*;

	localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
	localparam int FillWidth = $clog2(FifoDepth + 1);
	localparam int CreditWidth = $clog2(SinkCredits + 1);

	// One whole wordline per entry
	volt_t fifoMem [FifoDepth][CellCount];

	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [FillWidth-1:0] fill;
	logic [CreditWidth-1:0] credits;
	logic push;
	logic pop;
	logic fifoEmpty;
	logic fifoFull;

	// Pointer step with wrap for any depth
	function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
		return (ptr == PtrWidth'(FifoDepth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	//////////////////////////////
	// Push and pop
	//////////////////////////////

	assign push = &cellValid;
	assign fifoEmpty = (fill == '0);
	assign fifoFull = (fill == FillWidth'(FifoDepth));

	// Send only with data and a sink credit
	assign pop = !fifoEmpty && (credits != '0);
	assign outValid = pop;
	// Freed entry goes back upstream
	assign inCredit = pop;

	// Head entry drives the output
	always_comb
	begin
		for (int c = 0; c < CellCount; c++)
			outVth[c] = fifoMem[rdPtr][c];
	end

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			for (int c = 0; c < CellCount; c++)
				fifoMem[wrPtr][c] <= cellVth[c];
		end
	end

	//////////////////////////////
	// Pointers, fill and credits
	//////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			fill <= '0;
			credits <= CreditWidth'(SinkCredits);
		end
		else
		begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			case ({push, pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
			// Spend on send, regain on sink return
			case ({pop, outCredit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// All cells run in lockstep
	cellsAgree: assert property (@(posedge clk) disable iff (reset)
		(cellValid == '0) || (cellValid == '1));

	// Upstream credits keep the FIFO from overflowing
	noPushWhenFull: assert property (@(posedge clk) disable iff (reset)
		push |-> !fifoFull);

	// Sink never returns more than it got
	creditsBounded: assert property (@(posedge clk) disable iff (reset)
		int'(credits) <= SinkCredits);

endmodule

// File: cciChannel.sv
`timescale 1ns/10ps

module cciChannel #(
	parameter int WordLinesPerBlock = 8192,
	parameter int FifoDepth = 4
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input ccPkg::cellWord_t inWords [ccPkg::CellCount],
	output logic inCredit,
	output logic outValid,
	output ccPkg::volt_t outVth [ccPkg::CellCount],
	input logic outCredit
);
	import ccPkg::*;

	//////////////////////////////
	// Internal wiring
	//////////////////////////////

	// One lane per cell
	cciLaneIf lane [CellCount] ();

	logic [CellCount-1:0] cellValid;
	volt_t cellVth [CellCount];

	// Present and previous wordline, steps and block counter
	wordLineLoader #(
		.WordLinesPerBlock(WordLinesPerBlock)
	) i_loader (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inWords(inWords),
		.lane(lane)
	);

	// Cell array
	for (genvar c = 0; c < CellCount; c++)
	begin : gCell
		couplingCell i_cell (
			.clk(clk),
			.reset(reset),
			.lane(lane[c]),
			.cellValid(cellValid[c]),
			.cellVth(cellVth[c])
		);
	end

	// Output FIFO and both credit loops
	vthCollector #(
		.FifoDepth(FifoDepth)
	) i_collector (
		.clk(clk),
		.reset(reset),
		.cellValid(cellValid),
		.cellVth(cellVth),
		.outValid(outValid),
		.outVth(outVth),
		.outCredit(outCredit),
		.inCredit(inCredit)
	);

endmodule

// File: ccChecker.sv
`timescale 1ns/10ps

module ccChecker #(
	parameter int WordLinesPerBlock = 8192
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input ccPkg::cellWord_t inWords [ccPkg::CellCount],
	input logic inCredit,
	input logic outValid,
	input ccPkg::volt_t outVth [ccPkg::CellCount],
	input logic outCredit,
	output int checkedCount,
	output int errorCount
);
	import ccPkg::*;

	localparam int LineBits = CellCount * VoltWidth;
	localparam int VoltMax = (1 << VoltWidth) - 1;

	// Expected wordlines in output order
	logic [LineBits-1:0] expQ [$];
	// Programmed voltages of the last accepted wordline
	int prevProg [CellCount];
	int blockPos;
	int sinkCredits;

	// Programming step, negative counts as none
	function automatic int clampStep(input cellWord_t w);
		int diff;
		diff = int'(w.programmed) - int'(w.initVolt);
		return (diff < 0) ? 0 : diff;
	endfunction

	//////////////////////////////
	// Reference model
	//////////////////////////////

	task automatic modelWordLine();
		int steps [CellCount];
		int left;
		int right;
		int v;
		logic [LineBits-1:0] line;
		// Block start brings no coupling
		for (int c = 0; c < CellCount; c++)
			steps[c] = (blockPos == 0) ? 0 : clampStep(inWords[c]);
		for (int c = 0; c < CellCount; c++)
		begin
			left = (c == 0) ? 0 : steps[c-1];
			right = (c == CellCount - 1) ? 0 : steps[c+1];
			v = prevProg[c] + (CouplingY * steps[c] + CouplingXY * (left + right))
				/ (1 << CouplingShift);
			if (v > VoltMax)
				v = VoltMax;
			line[c*VoltWidth +: VoltWidth] = VoltWidth'(v);
		end
		expQ.push_back(line);
		for (int c = 0; c < CellCount; c++)
			prevProg[c] = int'(inWords[c].programmed);
		blockPos = (blockPos + 1) % WordLinesPerBlock;
	endtask

	// One report line per output wordline
	task automatic compareOutput();
		logic [LineBits-1:0] want;
		int bad;
		int firstBad;
		bad = 0;
		firstBad = 0;
		if (expQ.size() == 0)
		begin
			$display("Output wordline appeared with no accepted wordline behind it");
			errorCount++;
			return;
		end
		want = expQ.pop_front();
		for (int c = 0; c < CellCount; c++)
		begin
			if (outVth[c] !== want[c*VoltWidth +: VoltWidth])
			begin
				if (bad == 0)
					firstBad = c;
				bad++;
			end
		end
		checkedCount++;
		if (bad == 0)
			$display("Test %0d passed", checkedCount);
		else
		begin
			$display("Error %0d ns: test %0d cell %0d outVth %h expected %h, %0d cells wrong",
				$time, checkedCount, firstBad, outVth[firstBad],
				want[firstBad*VoltWidth +: VoltWidth], bad);
			errorCount++;
		end
	endtask

	//////////////////////////////
	// Sampling
	//////////////////////////////

	always @(posedge clk)
	begin
		if (reset)
		begin
			expQ.delete();
			for (int c = 0; c < CellCount; c++)
				prevProg[c] = 0;
			blockPos = 0;
			sinkCredits = SinkCredits;
			checkedCount = 0;
			errorCount = 0;
		end
		else
		begin
			if (inValid)
				modelWordLine();
			if (outValid)
				compareOutput();
			// One upstream credit per output
			if (inCredit !== outValid)
			begin
				$display("Error %0d ns: inCredit %b with outValid %b", $time, inCredit, outValid);
				errorCount++;
			end
			if (outValid && sinkCredits == 0)
			begin
				$display("Error %0d ns: outValid sent with no sink credit left", $time);
				errorCount++;
			end
			sinkCredits = sinkCredits - (outValid ? 1 : 0) + (outCredit ? 1 : 0);
		end
	end

endmodule

// File: ccTb.sv
`timescale 1ns/10ps

module ccTb;
	import ccPkg::*;

	localparam int WordLinesPerBlock = 4;
	localparam int FifoDepth = 4;
	localparam int NumTests = 12;
	localparam int HoldCycles = 24;
	// Slot per wordline covers hold windows and credit delays
	localparam int CycleLimit = NumTests * 40 + 100;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic inValid = 1'b0;
	cellWord_t inWords [CellCount];
	logic inCredit;
	logic outValid;
	volt_t outVth [CellCount];
	logic outCredit = 1'b0;

	int checkedCount;
	int errorCount;
	int cycleCount = 0;
	int sentCount = 0;
	int creditsBack = 0;
	int outputsSeen = 0;
	int creditsReturned = 0;
	int holdUntil = 0;
	int creditDelay = 0;
	logic [31:0] lfsrState = 32'h21731214;

	//////////////////////////////
	// Stimulus table
	//////////////////////////////

	// Words, sink hold flag, credit return delay
	logic [WordWidth-1:0] tableWords [NumTests][CellCount];
	bit tableHold [NumTests];
	int tableDelay [NumTests];

	cciChannel #(
		.WordLinesPerBlock(WordLinesPerBlock),
		.FifoDepth(FifoDepth)
	) i_dut (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inWords(inWords),
		.inCredit(inCredit),
		.outValid(outValid),
		.outVth(outVth),
		.outCredit(outCredit)
	);

	ccChecker #(
		.WordLinesPerBlock(WordLinesPerBlock)
	) i_checker (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inWords(inWords),
		.inCredit(inCredit),
		.outValid(outValid),
		.outVth(outVth),
		.outCredit(outCredit),
		.checkedCount(checkedCount),
		.errorCount(errorCount)
	);

	always #50 clk = ~clk;

	// Galois LFSR, one step per bit
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			bits = {bits[30:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'hA3000000) : (lfsrState >> 1);
		end
		return bits;
	endfunction

	task automatic buildTable();
		for (int t = 0; t < NumTests; t++)
		begin
			for (int c = 0; c < CellCount; c++)
				tableWords[t][c] = takeBits(32);
			tableDelay[t] = int'(takeBits(2));
			tableHold[t] = (t == 5) || (t == 9);
		end
		// Row 2 all negative steps, row 3 full scale steps
		for (int c = 0; c < CellCount; c++)
		begin
			tableWords[2][c] = {16'hFFF0, 16'hFFFF};
			tableWords[3][c] = {16'hFFFF, 16'h0000};
		end
	endtask

	//////////////////////////////
	// Credits and timeout
	//////////////////////////////

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (inCredit)
			creditsBack <= creditsBack + 1;
		if (outValid)
			outputsSeen <= outputsSeen + 1;
		if (cycleCount >= CycleLimit)
		begin
			$display("Timeout: %0d of %0d wordlines came out in %0d cycles",
				checkedCount, NumTests, cycleCount);
			$display("Test failed");
			$finish;
		end
	end

	// Sink hands credits back after a short delay unless held
	always @(negedge clk)
	begin
		outCredit = 1'b0;
		if (!reset && cycleCount >= holdUntil && outputsSeen > creditsReturned
			&& creditsReturned < NumTests)
		begin
			if (creditDelay < tableDelay[creditsReturned])
				creditDelay++;
			else
			begin
				outCredit = 1'b1;
				creditsReturned++;
				creditDelay = 0;
			end
		end
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin
		for (int c = 0; c < CellCount; c++)
			inWords[c] = '0;
		buildTable();
		repeat (4) @(negedge clk);
		reset = 1'b0;
		for (int t = 0; t < NumTests; t++)
		begin
			if (tableHold[t])
				holdUntil = cycleCount + HoldCycles;
			// Spend an upstream credit
			while (sentCount - creditsBack >= FifoDepth)
				@(negedge clk);
			for (int c = 0; c < CellCount; c++)
				inWords[c] = tableWords[t][c];
			inValid = 1'b1;
			sentCount++;
			@(negedge clk);
			inValid = 1'b0;
		end
		wait (checkedCount >= NumTests);
		// Room for any stray output
		repeat (8) @(negedge clk);
		$display("Closing report: %0d of %0d wordlines checked, %0d errors",
			checkedCount, NumTests, errorCount);
		if (errorCount == 0 && checkedCount == NumTests)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: sim.f
ccPkg.sv
cciLaneIf.sv
wordLineLoader.sv
couplingCell.sv
vthCollector.sv
cciChannel.sv
ccChecker.sv
ccTb.sv

// File: run.sh
#!/bin/bash
# Build and run the channel testbench with Verilator
verilator --binary --timing --assert -f sim.f --top-module ccTb -o ccSim \
	&& ./obj_dir/ccSim | tee /dev/stderr | grep -q "Test completed successfully" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
